//--- files.f
hw/soc_pkg.sv
hw/bus_decoder.sv
hw/boot_rom.sv
hw/ram_block.sv
hw/machine_timer.sv
hw/soc_fabric.sv
testbench/clock_gen.sv
testbench/tb_soc_fabric.sv

//--- Makefile
# Verilator build and run of the SoC bus fabric testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build tb_soc_fabric with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/10ps \
		--top-module tb_soc_fabric -f files.f
	./obj_dir/Vtb_soc_fabric

clean:
	rm -rf obj_dir

//--- hw/rom.hex
// One 32-bit word per line, ROM word index 0 to 15 in order
10000137
00010113
0000a0b7
00808093
0000a023
00100193
00312223
00012283
00128293
00512023
fe0298e3
00000513
00a00893
00000073
0000006f
deadbeef

//--- testbench/tb_soc_fabric.sv
`timescale 1ns/10ps

module tb_soc_fabric;
	import soc_pkg::*;

	localparam int READY_TIMEOUT = 16;
	localparam int RESET_TIMEOUT = 64;
	localparam int IRQ_TIMEOUT   = 200;
	localparam int ROM_READS     = 24;
	localparam int RAM_WRITES    = 48;
	localparam int FAULT_CYCLES  = 6;

	logic  clock;
	logic  i_rst_n;
	logic  i_bus_request;
	logic  i_bus_rw;
	word_t i_bus_address;
	word_t i_bus_wdata;
	word_t o_bus_rdata;
	logic  o_bus_ready;
	logic  o_bus_fault;
	logic  o_timer_interrupt;

	// Reference model state
	word_t       rom_model [ROM_WORDS];
	word_t       ram_model [RAM_WORDS];
	logic [63:0] cmp_model;
	word_t       lfsr_state;

	// Reads waiting for the comparing process
	word_t expected_q [$];
	word_t actual_q [$];
	word_t ram_addrs [$];

	clock_gen clocks (.clock(clock), .o_rst_n(i_rst_n));

	soc_fabric i_dut (
		.clock            (clock),
		.i_rst_n          (i_rst_n),
		.i_bus_request    (i_bus_request),
		.i_bus_rw         (i_bus_rw),
		.i_bus_address    (i_bus_address),
		.i_bus_wdata      (i_bus_wdata),
		.o_bus_rdata      (o_bus_rdata),
		.o_bus_ready      (o_bus_ready),
		.o_bus_fault      (o_bus_fault),
		.o_timer_interrupt(o_timer_interrupt)
	);

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Simulation failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_value(input string name, input word_t actual, input word_t expected);
		if (actual !== expected)
			abort_run($sformatf("Fail %s: got 0x%08h, expected 0x%08h", name, actual, expected));
	endtask

	// ====================
	// Random values
	// ====================

	// Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
	function automatic word_t random_bits(input int count);
		word_t value;
		logic  feedback;
		value = '0;
		for (int i = 0; i < count; i++) begin
			feedback   = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], feedback};
			value      = {value[30:0], feedback};
		end
		return value;
	endfunction

	function automatic word_t random_address(input logic [3:0] region);
		word_t offset;
		offset = random_bits(OFFSET_W - WORD_LSB) << WORD_LSB;
		return {region, offset[OFFSET_W-1:0]};
	endfunction

	function automatic word_t timer_address(input logic [1:0] reg_sel);
		return {REGION_TIMER, 24'h0, reg_sel, 2'b00};
	endfunction

	// ====================
	// Reference model
	// ====================

	function automatic int word_index(input word_t address, input int depth);
		word_t offset;
		offset = {4'h0, address[OFFSET_W-1:0]};
		return int'((offset >> WORD_LSB) % word_t'(depth));
	endfunction

	function automatic word_t expected_read(input word_t address);
		logic [1:0] reg_sel;
		reg_sel = 2'(word_index(address, 4));
		case (address[REGION_MSB:REGION_LSB])
			REGION_ROM: return rom_model[word_index(address, ROM_WORDS)];
			REGION_RAM: return ram_model[word_index(address, RAM_WORDS)];
			REGION_TIMER: begin
				if (reg_sel == TIMER_CMP_LO)
					return cmp_model[31:0];
				if (reg_sel == TIMER_CMP_HI)
					return cmp_model[63:32];
				return '0;
			end
			default: return '0;
		endcase
	endfunction

	// ROM and time words ignore writes
	function automatic void apply_write(input word_t address, input word_t data);
		logic [1:0] reg_sel;
		reg_sel = 2'(word_index(address, 4));
		if (address[REGION_MSB:REGION_LSB] == REGION_RAM)
			ram_model[word_index(address, RAM_WORDS)] = data;
		else if (address[REGION_MSB:REGION_LSB] == REGION_TIMER) begin
			if (reg_sel == TIMER_CMP_LO)
				cmp_model[31:0] = data;
			else if (reg_sel == TIMER_CMP_HI)
				cmp_model[63:32] = data;
		end
	endfunction

	// ====================
	// Bus master
	// ====================

	task automatic bus_transfer(input logic rw, input word_t address, input word_t wdata,
		input logic check_read, output word_t rdata);
		int cycles;
		cycles = 0;
		@(negedge clock);
		i_bus_request = 1'b1;
		i_bus_rw      = rw;
		i_bus_address = address;
		i_bus_wdata   = wdata;
		while (!o_bus_ready && cycles < READY_TIMEOUT) begin
			@(negedge clock);
			cycles++;
		end
		if (!o_bus_ready)
			abort_run($sformatf("No ready from the bus for address 0x%08h", address));
		rdata         = o_bus_rdata;
		i_bus_request = 1'b0;
		check_value("ready latency", word_t'(cycles), 32'd1);
		if (rw)
			apply_write(address, wdata);
		else if (check_read) begin
			expected_q.push_back(expected_read(address));
			actual_q.push_back(rdata);
		end
	endtask

	// Comparing process for every checked read
	always @(negedge clock) begin
		word_t actual;
		word_t expected;
		while (actual_q.size() > 0) begin
			actual   = actual_q.pop_front();
			expected = expected_q.pop_front();
			check_value("o_bus_rdata", actual, expected);
		end
	end

	initial begin
		#5_000_000;
		abort_run("Watchdog expired before the test finished");
	end

	// ====================
	// Stimulus
	// ====================

	initial begin
		int    cycles;
		int    j;
		word_t rdata;
		word_t first;
		word_t address;
		i_bus_request = 1'b0;
		i_bus_rw      = 1'b0;
		i_bus_address = '0;
		i_bus_wdata   = '0;
		lfsr_state    = 32'hc4eb_0742;
		cmp_model     = '1;
		$readmemh("hw/rom.hex", rom_model);

		cycles = 0;
		while (!i_rst_n && cycles < RESET_TIMEOUT) begin
			@(negedge clock);
			cycles++;
		end
		if (!i_rst_n)
			abort_run("Reset was never released");
		@(negedge clock);
		check_value("o_bus_ready", 32'(o_bus_ready), 32'd0);
		check_value("o_bus_fault", 32'(o_bus_fault), 32'd0);
		check_value("o_timer_interrupt", 32'(o_timer_interrupt), 32'd0);

		// Boot ROM reads, then a write that must not stick
		for (int i = 0; i < ROM_READS; i++)
			bus_transfer(1'b0, random_address(REGION_ROM), '0, 1'b1, rdata);
		address = random_address(REGION_ROM);
		bus_transfer(1'b1, address, random_bits(32), 1'b0, rdata);
		bus_transfer(1'b0, address, '0, 1'b1, rdata);

		// RAM writes, read back in shuffled order
		for (int i = 0; i < RAM_WRITES; i++) begin
			address = random_address(REGION_RAM);
			ram_addrs.push_back(address);
			bus_transfer(1'b1, address, random_bits(32), 1'b0, rdata);
		end
		for (int i = RAM_WRITES - 1; i > 0; i--) begin
			j            = int'(random_bits(16) % word_t'(i + 1));
			address      = ram_addrs[i];
			ram_addrs[i] = ram_addrs[j];
			ram_addrs[j] = address;
		end
		foreach (ram_addrs[i])
			bus_transfer(1'b0, ram_addrs[i], '0, 1'b1, rdata);

		// Unmapped region holds fault and never answers
		@(negedge clock);
		i_bus_request = 1'b1;
		i_bus_rw      = 1'b0;
		i_bus_address = random_address(4'h5);
		for (int i = 0; i < FAULT_CYCLES; i++) begin
			@(negedge clock);
			check_value("o_bus_fault", 32'(o_bus_fault), 32'd1);
			check_value("o_bus_ready", 32'(o_bus_ready), 32'd0);
		end
		i_bus_request = 1'b0;
		@(negedge clock);
		check_value("o_bus_fault", 32'(o_bus_fault), 32'd0);

		// Time counter never runs backwards
		for (int i = 0; i < 5; i++) begin
			bus_transfer(1'b0, timer_address(TIMER_MTIME_LO), '0, 1'b0, first);
			repeat (6) @(negedge clock);
			bus_transfer(1'b0, timer_address(TIMER_MTIME_LO), '0, 1'b0, rdata);
			if (rdata < first)
				abort_run("Time counter low word decreased between two reads");
		end

		// Low half first so compare never passes through a small value
		bus_transfer(1'b0, timer_address(TIMER_MTIME_LO), '0, 1'b0, first);
		bus_transfer(1'b1, timer_address(TIMER_CMP_LO), first + 32'd8, 1'b0, rdata);
		bus_transfer(1'b1, timer_address(TIMER_CMP_HI), '0, 1'b0, rdata);
		bus_transfer(1'b0, timer_address(TIMER_CMP_LO), '0, 1'b1, rdata);
		bus_transfer(1'b0, timer_address(TIMER_CMP_HI), '0, 1'b1, rdata);
		cycles = 0;
		while (!o_timer_interrupt && cycles < IRQ_TIMEOUT) begin
			@(negedge clock);
			cycles++;
		end
		if (!o_timer_interrupt)
			abort_run("Timer interrupt did not rise after compare was set");
		bus_transfer(1'b1, timer_address(TIMER_CMP_HI), '1, 1'b0, rdata);
		bus_transfer(1'b1, timer_address(TIMER_CMP_LO), '1, 1'b0, rdata);
		cycles = 0;
		while (o_timer_interrupt && cycles < READY_TIMEOUT) begin
			@(negedge clock);
			cycles++;
		end
		if (o_timer_interrupt)
			abort_run("Timer interrupt stayed high after compare was cleared");

		cycles = 0;
		while (actual_q.size() > 0 && cycles < READY_TIMEOUT) begin
			@(negedge clock);
			cycles++;
		end
		if (actual_q.size() > 0)
			abort_run("Comparing process left reads unchecked");
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

//--- testbench/clock_gen.sv
`timescale 1ns/10ps

module clock_gen (
	output logic clock,
	output logic o_rst_n
);
	// 40 ns period
	localparam int HALF_PERIOD  = 20;
	localparam int RESET_CYCLES = 16;

	initial begin
		clock = 1'b0;
		forever #HALF_PERIOD clock = ~clock;
	end

	// Release reset on a falling edge, away from the DUT's active edge
	initial begin
		o_rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clock);
		@(negedge clock);
		o_rst_n = 1'b1;
	end

endmodule

//--- hw/soc_fabric.sv
`timescale 1ns/10ps

module soc_fabric (
	input  logic           clock,
	input  logic           i_rst_n,

	// Bus master port
	input  logic           i_bus_request,
	input  logic           i_bus_rw,
	input  soc_pkg::word_t i_bus_address,
	input  soc_pkg::word_t i_bus_wdata,
	output soc_pkg::word_t o_bus_rdata,
	output logic           o_bus_ready,
	output logic           o_bus_fault,

	output logic           o_timer_interrupt
);
	import soc_pkg::*;

	logic [OFFSET_W-1:0] offset;

	logic  rom_request;
	word_t rom_rdata;
	logic  rom_ready;

	logic  ram_request;
	word_t ram_rdata;
	logic  ram_ready;

	logic  timer_request;
	word_t timer_rdata;
	logic  timer_ready;

	// ====================
	// Address decode and response mux
	// ====================

	bus_decoder decoder (
		.i_bus_request  (i_bus_request),
		.i_bus_address  (i_bus_address),
		.o_offset       (offset),
		.o_rom_request  (rom_request),
		.o_ram_request  (ram_request),
		.o_timer_request(timer_request),
		.i_rom_rdata    (rom_rdata),
		.i_rom_ready    (rom_ready),
		.i_ram_rdata    (ram_rdata),
		.i_ram_ready    (ram_ready),
		.i_timer_rdata  (timer_rdata),
		.i_timer_ready  (timer_ready),
		.o_bus_rdata    (o_bus_rdata),
		.o_bus_ready    (o_bus_ready),
		.o_bus_fault    (o_bus_fault)
	);

	// ====================
	// Targets
	// ====================

	boot_rom rom (
		.clock    (clock),
		.i_rst_n  (i_rst_n),
		.i_request(rom_request),
		.i_offset (offset),
		.o_rdata  (rom_rdata),
		.o_ready  (rom_ready)
	);

	ram_block ram (
		.clock    (clock),
		.i_rst_n  (i_rst_n),
		.i_request(ram_request),
		.i_rw     (i_bus_rw),
		.i_offset (offset),
		.i_wdata  (i_bus_wdata),
		.o_rdata  (ram_rdata),
		.o_ready  (ram_ready)
	);

	machine_timer timer (
		.clock      (clock),
		.i_rst_n    (i_rst_n),
		.i_request  (timer_request),
		.i_rw       (i_bus_rw),
		.i_offset   (offset),
		.i_wdata    (i_bus_wdata),
		.o_rdata    (timer_rdata),
		.o_ready    (timer_ready),
		.o_interrupt(o_timer_interrupt)
	);

endmodule

//--- hw/machine_timer.sv
`timescale 1ns/10ps

module machine_timer (
	input  logic                         clock,
	input  logic                         i_rst_n,
	input  logic                         i_request,
	input  logic                         i_rw,
	input  logic [soc_pkg::OFFSET_W-1:0] i_offset,
	input  soc_pkg::word_t               i_wdata,
	output soc_pkg::word_t               o_rdata,
	output logic                         o_ready,
	output logic                         o_interrupt
);
	import soc_pkg::*;

	localparam int                    PRESCALE_W    = $clog2(TICK_DIVIDE);
	localparam logic [PRESCALE_W-1:0] PRESCALE_LAST = PRESCALE_W'(TICK_DIVIDE - 1);

	logic [PRESCALE_W-1:0] prescale;
	logic                  tick;
	logic [63:0]           mtime;
	logic [63:0]           mtimecmp;
	logic [1:0]            reg_index;
	logic                  request_q;
	logic                  access;

	assign reg_index = i_offset[WORD_LSB +: 2];

	// First cycle of a request
	assign access = i_request & ~request_q;

	// ====================
	// Time base
	// ====================

	assign tick = (prescale == PRESCALE_LAST);

	always_ff @(posedge clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			prescale <= '0;
			mtime    <= '0;
		end else begin
			prescale <= tick ? '0 : prescale + 1'b1;
			if (tick)
				mtime <= mtime + 64'd1;
		end
	end

	// ====================
	// Compare and interrupt
	// ====================

	always_ff @(posedge clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			mtimecmp    <= '1;
			o_interrupt <= 1'b0;
		end else begin
			// Time words are read-only from the bus
			if (access && i_rw) begin
				if (reg_index == TIMER_CMP_LO)
					mtimecmp[31:0] <= i_wdata;
				else if (reg_index == TIMER_CMP_HI)
					mtimecmp[63:32] <= i_wdata;
			end
			o_interrupt <= (mtime >= mtimecmp);
		end
	end

	// ====================
	// Register access
	// ====================

	always_ff @(posedge clock) begin
		if (i_request) begin
			case (reg_index)
				TIMER_MTIME_LO: o_rdata <= mtime[31:0];
				TIMER_MTIME_HI: o_rdata <= mtime[63:32];
				TIMER_CMP_LO:   o_rdata <= mtimecmp[31:0];
				default:        o_rdata <= mtimecmp[63:32];
			endcase
		end
	end

	always_ff @(posedge clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			request_q <= 1'b0;
			o_ready   <= 1'b0;
		end else begin
			request_q <= i_request;
			o_ready   <= access;
		end
	end

	// Register select and direction stay put while the master waits
	assert property (@(posedge clock) disable iff (!i_rst_n)
		i_request && request_q |-> $stable(i_offset) && $stable(i_rw))
	else $error("machine_timer: register select changed during a request");

endmodule

//--- hw/ram_block.sv
`timescale 1ns/10ps

module ram_block (
	input  logic                         clock,
	input  logic                         i_rst_n,
	input  logic                         i_request,
	input  logic                         i_rw,
	input  logic [soc_pkg::OFFSET_W-1:0] i_offset,
	input  soc_pkg::word_t               i_wdata,
	output soc_pkg::word_t               o_rdata,
	output logic                         o_ready
);
	import soc_pkg::*;

	localparam int INDEX_W = $clog2(RAM_WORDS);

	word_t              ram_mem [RAM_WORDS];
	logic [INDEX_W-1:0] ram_index;
	logic               request_q;

	assign ram_index = i_offset[WORD_LSB +: INDEX_W];

	// ====================
	// Storage
	// ====================

	always_ff @(posedge clock) begin
		if (i_request && i_rw)
			ram_mem[ram_index] <= i_wdata;
		if (i_request)
			o_rdata <= ram_mem[ram_index];
	end

	// ====================
	// Handshake
	// ====================

	// One ready per request, then quiet until request drops
	always_ff @(posedge clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			request_q <= 1'b0;
			o_ready   <= 1'b0;
		end else begin
			request_q <= i_request;
			o_ready   <= i_request & ~request_q;
		end
	end

	// Master holds address, direction and data for the whole request
	assert property (@(posedge clock) disable iff (!i_rst_n)
		i_request && request_q |-> $stable(i_offset) && $stable(i_rw) && $stable(i_wdata))
	else $error("ram_block: transfer changed during a request");

endmodule

//--- hw/boot_rom.sv
`timescale 1ns/10ps

module boot_rom (
	input  logic                         clock,
	input  logic                         i_rst_n,
	input  logic                         i_request,
	input  logic [soc_pkg::OFFSET_W-1:0] i_offset,
	output soc_pkg::word_t               o_rdata,
	output logic                         o_ready
);
	import soc_pkg::*;

	localparam int INDEX_W = $clog2(ROM_WORDS);

	word_t              rom_mem [ROM_WORDS];
	logic [INDEX_W-1:0] rom_index;
	logic               request_q;

	initial begin
		$readmemh("hw/rom.hex", rom_mem);
	end

	// Word index wraps over the ROM depth
	assign rom_index = i_offset[WORD_LSB +: INDEX_W];

	always_ff @(posedge clock) begin
		if (i_request)
			o_rdata <= rom_mem[rom_index];
	end

	// Answer once per request, writes included
	always_ff @(posedge clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			request_q <= 1'b0;
			o_ready   <= 1'b0;
		end else begin
			request_q <= i_request;
			o_ready   <= i_request & ~request_q;
		end
	end

	// Master holds the address for the whole request
	assert property (@(posedge clock) disable iff (!i_rst_n)
		i_request && request_q |-> $stable(i_offset))
	else $error("boot_rom: offset changed during a request");

endmodule

//--- hw/bus_decoder.sv
`timescale 1ns/10ps

module bus_decoder (
	input  logic                         i_bus_request,
	input  soc_pkg::word_t               i_bus_address,
	output logic [soc_pkg::OFFSET_W-1:0] o_offset,

	// Per-target requests
	output logic                         o_rom_request,
	output logic                         o_ram_request,
	output logic                         o_timer_request,

	// Target responses
	input  soc_pkg::word_t               i_rom_rdata,
	input  logic                         i_rom_ready,
	input  soc_pkg::word_t               i_ram_rdata,
	input  logic                         i_ram_ready,
	input  soc_pkg::word_t               i_timer_rdata,
	input  logic                         i_timer_ready,

	// Response to the master
	output soc_pkg::word_t               o_bus_rdata,
	output logic                         o_bus_ready,
	output logic                         o_bus_fault
);
	import soc_pkg::*;

	logic [REGION_MSB-REGION_LSB:0] region;
	logic                           rom_select;
	logic                           ram_select;
	logic                           timer_select;
	logic                           any_select;

	// ====================
	// Region decode
	// ====================

	assign region   = i_bus_address[REGION_MSB:REGION_LSB];
	assign o_offset = i_bus_address[OFFSET_W-1:0];

	assign rom_select   = (region == REGION_ROM);
	assign ram_select   = (region == REGION_RAM);
	assign timer_select = (region == REGION_TIMER);
	assign any_select   = rom_select | ram_select | timer_select;

	// Only the addressed target sees the request
	assign o_rom_request   = i_bus_request & rom_select;
	assign o_ram_request   = i_bus_request & ram_select;
	assign o_timer_request = i_bus_request & timer_select;

	// Unclaimed address, held as long as the master keeps requesting
	assign o_bus_fault = i_bus_request & ~any_select;

	// ====================
	// Response mux
	// ====================

	always_comb begin
		if (rom_select) begin
			o_bus_rdata = i_rom_rdata;
			o_bus_ready = i_rom_ready;
		end else if (ram_select) begin
			o_bus_rdata = i_ram_rdata;
			o_bus_ready = i_ram_ready;
		end else if (timer_select) begin
			o_bus_rdata = i_timer_rdata;
			o_bus_ready = i_timer_ready;
		end else begin
			// Nothing answers here
			o_bus_rdata = '0;
			o_bus_ready = 1'b0;
		end
	end

endmodule

//--- hw/soc_pkg.sv
package soc_pkg;

	// ====================
	// Bus widths
	// ====================

	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;

	typedef logic [DATA_W-1:0] word_t;

	// ====================
	// Address map
	// ====================

	// Top nibble of the address selects the target
	localparam int REGION_MSB = ADDR_W - 1;
	localparam int REGION_LSB = 28;
	localparam int OFFSET_W   = REGION_LSB;

	localparam logic [3:0] REGION_ROM   = 4'h0;
	localparam logic [3:0] REGION_RAM   = 4'h1;
	localparam logic [3:0] REGION_TIMER = 4'hA;

	// Memory depths in words
	localparam int ROM_WORDS = 16;
	localparam int RAM_WORDS = 1024;
	localparam int WORD_LSB  = 2;

	// ====================
	// Machine timer
	// ====================

	localparam int TICK_DIVIDE = 4;

	localparam logic [1:0] TIMER_MTIME_LO = 2'd0;
	localparam logic [1:0] TIMER_MTIME_HI = 2'd1;
	localparam logic [1:0] TIMER_CMP_LO   = 2'd2;
	localparam logic [1:0] TIMER_CMP_HI   = 2'd3;

endpackage
